// File: rtl/sd_pkg.sv
package sd_pkg;

    typedef enum logic [1:0] {
        CMD_IDLE,
        CMD_TX,
        CMD_WAIT,
        CMD_RX
    } cmd_state_t;

    localparam int SD_CLK_DIV = 4; // System clocks per card clock, must be even.
    localparam int CLK_CNT_W  = $clog2(SD_CLK_DIV);

    localparam int CMD_FRAME_BITS = 48; // Command frame and short response.
    localparam int LONG_RSP_BITS  = 136;

    // Bits ahead of the CRC field in a command or short response.
    localparam int CMD_CRC_BITS   = CMD_FRAME_BITS - 8;
    localparam int LONG_CRC_FIRST = 8; // Long response CRC skips the first byte.

    localparam int BIT_CNT_W = $clog2(LONG_RSP_BITS + 1);

    localparam int RSP_TIMEOUT = 64; // Card clock rising edges.
    localparam int RSP_WIDTH   = 128;

    localparam logic [5:0] RESERVED_INDEX = 6'h3F;

endpackage

// File: rtl/sd_clock_gen.sv
`timescale 1ns/1ps

module sd_clock_gen
    import sd_pkg::*;
(
    input  logic clk,
    input  logic reset,

    output logic sd_clk,
    output logic sd_clk_rising,
    output logic sd_clk_falling
);

    logic [CLK_CNT_W-1:0] div_count;
    logic                 rise_now;
    logic                 fall_now;

    // Card clock goes high at mid period and low at the period end.
    assign rise_now = (div_count == CLK_CNT_W'(SD_CLK_DIV / 2 - 1));
    assign fall_now = (div_count == CLK_CNT_W'(SD_CLK_DIV - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            div_count      <= '0;
            sd_clk         <= 1'b0;
            sd_clk_rising  <= 1'b0;
            sd_clk_falling <= 1'b0;
        end else begin
            if (fall_now) begin
                div_count <= '0;
            end else begin
                div_count <= div_count + 1'b1;
            end

            sd_clk_rising  <= rise_now; // Same edge as the sd_clk register.
            sd_clk_falling <= fall_now;

            if (rise_now) begin
                sd_clk <= 1'b1;
            end else if (fall_now) begin
                sd_clk <= 1'b0;
            end
        end
    end

    // Each strobe marks one edge of sd_clk, so the two never coincide.
    assert property (@(posedge clk) disable iff (reset)
        (sd_clk_rising == (sd_clk && !$past(sd_clk)))
        && (sd_clk_falling == (!sd_clk && $past(sd_clk))))
        else $error("sd_clock_gen: strobe does not match an sd_clk edge");

endmodule

// File: rtl/sd_crc_7.sv
`timescale 1ns/1ps

module sd_crc_7 (
    input  logic       clk,
    input  logic       reset,
    input  logic       enable,
    input  logic       data,
    output logic [6:0] result
);

    logic feedback;

    assign feedback = data ^ result[6];

    always_ff @(posedge clk) begin
        if (reset) begin
            result <= 7'd0;
        end else if (enable) begin
            // x^7 + x^3 + 1.
            result <= {result[5:3], result[2] ^ feedback, result[1:0], feedback};
        end
    end

endmodule

// File: rtl/sd_cmd.sv
`timescale 1ns/1ps

module sd_cmd
    import sd_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 cmd_start,
    input  logic [5:0]           cmd_index,
    input  logic [31:0]          cmd_arg,
    input  logic                 cmd_skip_response,
    input  logic                 cmd_long_response,
    input  logic                 cmd_reserved_response,
    input  logic                 cmd_ignore_crc,
    output logic                 cmd_busy,
    output logic                 cmd_error,
    output logic [RSP_WIDTH-1:0] cmd_rsp,

    input  logic                 sd_clk_rising,
    input  logic                 sd_clk_falling,

    inout  wire                  sd_cmd
);

    cmd_state_t state;

    logic                 sd_cmd_oe;
    logic                 sd_cmd_out;
    logic                 sd_cmd_in;
    logic [BIT_CNT_W-1:0] bit_count;
    logic [7:0]           data_shift;

    logic                 crc_clear;
    logic                 crc_enable;
    logic                 crc_data;
    logic [6:0]           crc_result;

    logic [5:0]           expected_index;
    logic [BIT_CNT_W-1:0] rx_last_bit;
    logic                 rx_crc_range;

    assign sd_cmd = sd_cmd_oe ? sd_cmd_out : 1'bz;

    always_ff @(posedge clk) begin
        sd_cmd_in <= sd_cmd; // Input pad register.
    end

    assign cmd_busy = (state != CMD_IDLE);

    assign expected_index = cmd_reserved_response ? RESERVED_INDEX : cmd_index;
    assign rx_last_bit    = cmd_long_response ? BIT_CNT_W'(LONG_RSP_BITS - 1)
                                              : BIT_CNT_W'(CMD_FRAME_BITS - 1);

    always_comb begin
        if (cmd_long_response) begin
            rx_crc_range = (bit_count >= BIT_CNT_W'(LONG_CRC_FIRST))
                && (bit_count < BIT_CNT_W'(RSP_WIDTH));
        end else begin
            rx_crc_range = (bit_count < BIT_CNT_W'(CMD_CRC_BITS));
        end
    end

    // Start bit is zero, so leaving it out of the CRC changes nothing.
    assign crc_clear = (state == CMD_IDLE) || (state == CMD_WAIT);

    always_comb begin
        crc_enable = 1'b0;
        crc_data   = data_shift[7];
        case (state)
            CMD_TX: begin
                crc_enable = sd_clk_falling && (bit_count != '0)
                    && (bit_count <= BIT_CNT_W'(CMD_CRC_BITS));
            end
            CMD_RX: begin
                crc_enable = sd_clk_rising && rx_crc_range;
                crc_data   = sd_cmd_in;
            end
            default: begin
                crc_enable = 1'b0;
            end
        endcase
    end

    sd_crc_7 crc_inst (
        .clk    (clk),
        .reset  (crc_clear),
        .enable (crc_enable),
        .data   (crc_data),
        .result (crc_result)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= CMD_IDLE;
            bit_count  <= '0;
            cmd_error  <= 1'b0;
            sd_cmd_oe  <= 1'b0;
            sd_cmd_out <= 1'b1;
        end else begin
            case (state)
                CMD_IDLE: begin
                    if (cmd_start) begin
                        state      <= CMD_TX;
                        bit_count  <= '0;
                        cmd_error  <= 1'b0;
                        data_shift <= {2'b01, cmd_index};
                    end
                end

                CMD_TX: begin
                    if (sd_clk_falling) begin
                        bit_count <= bit_count + 1'b1;
                        if (bit_count == '0) begin
                            sd_cmd_oe  <= 1'b1; // Lead-in, line driven high.
                            sd_cmd_out <= 1'b1;
                        end else if (bit_count <= BIT_CNT_W'(CMD_FRAME_BITS)) begin
                            sd_cmd_out <= data_shift[7];
                            data_shift <= {data_shift[6:0], 1'b1};
                            case (bit_count)
                                BIT_CNT_W'(8):  data_shift <= cmd_arg[31:24];
                                BIT_CNT_W'(16): data_shift <= cmd_arg[23:16];
                                BIT_CNT_W'(24): data_shift <= cmd_arg[15:8];
                                BIT_CNT_W'(32): data_shift <= cmd_arg[7:0];
                                default: ;
                            endcase
                        end else begin
                            sd_cmd_oe <= 1'b0; // Release after the end bit.
                            bit_count <= '0;
                            state     <= cmd_skip_response ? CMD_IDLE : CMD_WAIT;
                        end
                    end else if (bit_count == BIT_CNT_W'(CMD_CRC_BITS + 1)) begin
                        // CRC has taken the last argument bit by now.
                        data_shift <= {crc_result, 1'b1};
                    end
                end

                CMD_WAIT: begin
                    if (sd_clk_rising) begin
                        data_shift <= {data_shift[6:0], sd_cmd_in};
                        if (!sd_cmd_in) begin
                            state     <= CMD_RX; // Start bit seen.
                            bit_count <= BIT_CNT_W'(1);
                        end else if (bit_count == BIT_CNT_W'(RSP_TIMEOUT - 1)) begin
                            state     <= CMD_IDLE;
                            cmd_error <= 1'b1;
                        end else begin
                            bit_count <= bit_count + 1'b1;
                        end
                    end
                end

                CMD_RX: begin
                    if (sd_clk_rising) begin
                        data_shift <= {data_shift[6:0], sd_cmd_in};
                        bit_count  <= bit_count + 1'b1;
                        if (bit_count[2:0] == 3'd0) begin
                            cmd_rsp <= {cmd_rsp[RSP_WIDTH-9:0], data_shift}; // Full byte.
                        end
                        if ((bit_count == BIT_CNT_W'(8)) && (data_shift[5:0] != expected_index)) begin
                            cmd_error <= 1'b1;
                        end
                        if (bit_count == rx_last_bit) begin
                            state <= CMD_IDLE;
                            // CRC field sits just below the end bit.
                            if (!cmd_ignore_crc && (data_shift[6:0] != crc_result)) begin
                                cmd_error <= 1'b1;
                            end
                        end
                    end
                end

                default: begin
                    state <= CMD_IDLE;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset) cmd_busy |-> !cmd_start)
        else $error("sd_cmd: cmd_start while busy");

    // Pin is only driven while a frame is going out.
    assert property (@(posedge clk) disable iff (reset) sd_cmd_oe |-> (state == CMD_TX))
        else $error("sd_cmd: output enable outside transmit");

endmodule

// File: rtl/sd_cmd_host.sv
`timescale 1ns/1ps

module sd_cmd_host
    import sd_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 cmd_start,
    input  logic [5:0]           cmd_index,
    input  logic [31:0]          cmd_arg,
    input  logic                 cmd_skip_response,
    input  logic                 cmd_long_response,
    input  logic                 cmd_reserved_response,
    input  logic                 cmd_ignore_crc,
    output logic                 cmd_busy,
    output logic                 cmd_error,
    output logic [RSP_WIDTH-1:0] cmd_rsp,

    output logic                 sd_clk,
    inout  wire                  sd_cmd
);

    logic sd_clk_rising;
    logic sd_clk_falling;

    sd_clock_gen clock_gen_inst (
        .clk            (clk),
        .reset          (reset),
        .sd_clk         (sd_clk),
        .sd_clk_rising  (sd_clk_rising),
        .sd_clk_falling (sd_clk_falling)
    );

    sd_cmd cmd_inst (
        .clk                   (clk),
        .reset                 (reset),
        .cmd_start             (cmd_start),
        .cmd_index             (cmd_index),
        .cmd_arg               (cmd_arg),
        .cmd_skip_response     (cmd_skip_response),
        .cmd_long_response     (cmd_long_response),
        .cmd_reserved_response (cmd_reserved_response),
        .cmd_ignore_crc        (cmd_ignore_crc),
        .cmd_busy              (cmd_busy),
        .cmd_error             (cmd_error),
        .cmd_rsp               (cmd_rsp),
        .sd_clk_rising         (sd_clk_rising),
        .sd_clk_falling        (sd_clk_falling),
        .sd_cmd                (sd_cmd)
    );

endmodule

// File: test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    localparam time HALF_PERIOD = 50; // 100 ns period.

    initial begin
        clk = 1'b0;
        forever begin
            #(HALF_PERIOD) clk = ~clk;
        end
    end

endmodule

// File: test/sd_card_model.sv
`timescale 1ns/1ps

module sd_card_model (
    input  logic         sd_clk,
    inout  wire          sd_cmd,

    input  logic [1:0]   rsp_kind,       // 0 none, 1 short, 2 long.
    input  logic [7:0]   rsp_delay,      // Card clocks after the frame, at least 1.
    input  logic         index_override,
    input  logic [5:0]   override_index,
    input  logic         crc_corrupt,
    input  logic [119:0] payload,

    output logic [47:0]  rx_frame,
    output logic         rx_released,
    output int           rx_count
);

    logic         drive_en;
    logic         drive_bit;
    logic [47:0]  frame;
    logic [135:0] rsp_bits;
    logic [5:0]   rsp_index;
    logic [6:0]   rsp_crc;
    int           rsp_len;
    int           i;

    assign sd_cmd = drive_en ? drive_bit : 1'bz;

    function automatic logic [6:0] crc7_serial(input logic [127:0] bits, input int len);
        logic [6:0] crc;
        logic       fb;
        int         k;
        crc = 7'd0;
        for (k = len - 1; k >= 0; k--) begin
            fb  = bits[k] ^ crc[6];
            crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return crc;
    endfunction

    task automatic send_response();
        int n;
        rsp_index = index_override ? override_index : frame[45:40];
        if (rsp_kind == 2'd2) begin
            rsp_crc  = crc7_serial({8'd0, payload}, 120) ^ {6'd0, crc_corrupt};
            rsp_bits = {2'b00, rsp_index, payload, rsp_crc, 1'b1};
            rsp_len  = 136;
        end else begin
            rsp_crc  = crc7_serial({88'd0, 2'b00, rsp_index, payload[31:0]}, 40)
                ^ {6'd0, crc_corrupt};
            rsp_bits = {88'd0, 2'b00, rsp_index, payload[31:0], rsp_crc, 1'b1};
            rsp_len  = 48;
        end
        repeat (rsp_delay) @(negedge sd_clk);
        for (n = rsp_len - 1; n >= 0; n--) begin
            drive_bit = rsp_bits[n]; // Host samples on the next rising edge.
            drive_en  = 1'b1;
            @(negedge sd_clk);
        end
        drive_en  = 1'b0;
        drive_bit = 1'b1;
    endtask

    initial begin
        drive_en    = 1'b0;
        drive_bit   = 1'b1;
        rx_frame    = '0;
        rx_released = 1'b0;
        rx_count    = 0;
        forever begin
            @(posedge sd_clk);
            if (sd_cmd === 1'b0) begin
                frame = '0; // Start bit already seen.
                for (i = 1; i < 48; i++) begin
                    @(posedge sd_clk);
                    frame = {frame[46:0], sd_cmd};
                end
                @(posedge sd_clk);
                rx_released = (sd_cmd === 1'b1);
                rx_frame    = frame;
                rx_count    = rx_count + 1;
                if (rsp_kind != 2'd0) begin
                    send_response();
                end
            end
        end
    end

endmodule

// File: test/tb_sd_cmd_host.sv
`timescale 1ns/1ps

module tb_sd_cmd_host;

    localparam int FRAME_BITS   = 48;
    localparam int LONG_BITS    = 136;
    localparam int RSP_WAIT     = 64;
    localparam int CARD_CLK_DIV = 4;
    localparam int NUM_TESTS    = 11;
    localparam int GAP_CYCLES   = 8;
    localparam int CYCLES_PER_TEST =
        (FRAME_BITS + 2 + RSP_WAIT + LONG_BITS) * CARD_CLK_DIV + GAP_CYCLES;
    localparam int CYCLE_LIMIT  = 2 * NUM_TESTS * CYCLES_PER_TEST; // Twice the worst case.

    localparam logic [1:0] RSP_NONE  = 2'd0;
    localparam logic [1:0] RSP_SHORT = 2'd1;
    localparam logic [1:0] RSP_LONG  = 2'd2;
    localparam logic       Y = 1'b1;
    localparam logic       N = 1'b0;

    typedef struct packed {
        logic [5:0]  index;
        logic [31:0] arg;
        logic        skip;
        logic        long_rsp;
        logic        reserved;
        logic        ignore_crc;
        logic [1:0]  kind;
        logic [7:0]  delay;
        logic        override_en;
        logic [5:0]  override_index;
        logic        corrupt;
        logic        expect_error;
    } row_t;

    logic         clk;
    logic         reset;
    logic         cmd_start;
    logic [5:0]   cmd_index;
    logic [31:0]  cmd_arg;
    logic         cmd_skip_response;
    logic         cmd_long_response;
    logic         cmd_reserved_response;
    logic         cmd_ignore_crc;
    logic         cmd_busy;
    logic         cmd_error;
    logic [127:0] cmd_rsp;
    logic         sd_clk;
    tri1          sd_cmd; // Board pull-up.

    logic [1:0]   card_kind;
    logic [7:0]   card_delay;
    logic         card_override;
    logic [5:0]   card_index;
    logic         card_corrupt;
    logic [119:0] card_payload;
    logic [47:0]  card_frame;
    logic         card_released;
    int           card_count;

    row_t         rows [NUM_TESTS];
    string        names [NUM_TESTS];
    int           pass_count;
    int           fail_count;
    int           cycle_count;

    tb_clock clock_inst (.clk(clk));

    sd_cmd_host UUT (
        .clk                   (clk),
        .reset                 (reset),
        .cmd_start             (cmd_start),
        .cmd_index             (cmd_index),
        .cmd_arg               (cmd_arg),
        .cmd_skip_response     (cmd_skip_response),
        .cmd_long_response     (cmd_long_response),
        .cmd_reserved_response (cmd_reserved_response),
        .cmd_ignore_crc        (cmd_ignore_crc),
        .cmd_busy              (cmd_busy),
        .cmd_error             (cmd_error),
        .cmd_rsp               (cmd_rsp),
        .sd_clk                (sd_clk),
        .sd_cmd                (sd_cmd)
    );

    sd_card_model card_inst (
        .sd_clk         (sd_clk),
        .sd_cmd         (sd_cmd),
        .rsp_kind       (card_kind),
        .rsp_delay      (card_delay),
        .index_override (card_override),
        .override_index (card_index),
        .crc_corrupt    (card_corrupt),
        .payload        (card_payload),
        .rx_frame       (card_frame),
        .rx_released    (card_released),
        .rx_count       (card_count)
    );

    // CRC7 over data[len-1:0], most significant bit first.
    function automatic logic [6:0] crc7(input logic [127:0] data, input int len);
        logic [6:0] crc;
        logic       top;
        int         b;
        crc = 7'd0;
        for (b = len - 1; b >= 0; b--) begin
            top = crc[6];
            crc = crc << 1;
            if (top != data[b]) begin
                crc = crc ^ 7'b0001001;
            end
        end
        return crc;
    endfunction

    task automatic fill_table();
        // index, arg, skip, long, reserved, ignore, kind, delay, override, index, corrupt, error.
        names[0]  = "go_idle_skip";
        rows[0]   = '{6'd0,  32'h0000_0000, Y, N, N, N, RSP_NONE,  8'd0,  N, 6'd0,  N, N};
        names[1]  = "send_if_cond";
        rows[1]   = '{6'd8,  32'h0000_01AA, N, N, N, N, RSP_SHORT, 8'd2,  N, 6'd0,  N, N};
        names[2]  = "app_cmd";
        rows[2]   = '{6'd55, 32'hA5A5_5A5A, N, N, N, N, RSP_SHORT, 8'd1,  N, 6'd0,  N, N};
        names[3]  = "short_delay_5";
        rows[3]   = '{6'd17, 32'h1234_5678, N, N, N, N, RSP_SHORT, 8'd5,  N, 6'd0,  N, N};
        names[4]  = "short_delay_30";
        rows[4]   = '{6'd13, 32'hFFFF_0001, N, N, N, N, RSP_SHORT, 8'd30, N, 6'd0,  N, N};
        names[5]  = "long_cid";
        rows[5]   = '{6'd2,  32'h0000_0000, N, Y, Y, N, RSP_LONG,  8'd3,  Y, 6'h3F, N, N};
        names[6]  = "r3_ignore_crc";
        rows[6]   = '{6'd41, 32'h40FF_8000, N, N, Y, Y, RSP_SHORT, 8'd2,  Y, 6'h3F, Y, N};
        names[7]  = "wrong_index";
        rows[7]   = '{6'd17, 32'h0000_0200, N, N, N, N, RSP_SHORT, 8'd2,  Y, 6'd18, N, Y};
        names[8]  = "bad_crc";
        rows[8]   = '{6'd7,  32'hDEAD_BEEF, N, N, N, N, RSP_SHORT, 8'd2,  N, 6'd0,  Y, Y};
        names[9]  = "silent_timeout";
        rows[9]   = '{6'd9,  32'h0001_0000, N, N, N, N, RSP_NONE,  8'd0,  N, 6'd0,  N, Y};
        names[10] = "select_skip";
        rows[10]  = '{6'd7,  32'h1234_0000, Y, N, N, N, RSP_NONE,  8'd0,  N, 6'd0,  N, N};
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        int           seed_value;
        int           t;
        int           wait_cycles;
        logic         test_failed;
        logic [39:0]  head;
        logic [47:0]  exp_frame;
        logic [5:0]   rsp_index;
        logic [39:0]  exp_short;
        logic [127:0] exp_long;
        logic [127:0] random_bits;

        seed_value  = $urandom(42270);
        pass_count  = 0;
        fail_count  = 0;
        cycle_count = 0;
        fill_table();

        reset                 = 1'b1;
        cmd_start             = 1'b0;
        cmd_index             = 6'd0;
        cmd_arg               = 32'd0;
        cmd_skip_response     = 1'b0;
        cmd_long_response     = 1'b0;
        cmd_reserved_response = 1'b0;
        cmd_ignore_crc        = 1'b0;
        card_kind             = RSP_NONE;
        card_delay            = 8'd1;
        card_override         = 1'b0;
        card_index            = 6'd0;
        card_corrupt          = 1'b0;
        card_payload          = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;
        repeat (GAP_CYCLES) @(negedge clk);

        for (t = 0; t < NUM_TESTS; t++) begin
            random_bits           = {$urandom, $urandom, $urandom, $urandom};
            cmd_index             = rows[t].index;
            cmd_arg               = rows[t].arg;
            cmd_skip_response     = rows[t].skip;
            cmd_long_response     = rows[t].long_rsp;
            cmd_reserved_response = rows[t].reserved;
            cmd_ignore_crc        = rows[t].ignore_crc;
            card_kind             = rows[t].kind;
            card_delay            = rows[t].delay;
            card_override         = rows[t].override_en;
            card_index            = rows[t].override_index;
            card_corrupt          = rows[t].corrupt;
            card_payload          = random_bits[119:0];
            cmd_start             = 1'b1;
            @(negedge clk);
            cmd_start   = 1'b0;
            test_failed = 1'b0;
            assert (cmd_busy === 1'b1) else begin
                $display("Test %s: cmd_busy did not rise after cmd_start", names[t]);
                test_failed = 1'b1;
            end
            while (cmd_busy) begin
                @(negedge clk);
            end

            // Card logs the frame one card clock after the end bit.
            wait_cycles = 0;
            while ((card_count != t + 1) && (wait_cycles < 4 * CARD_CLK_DIV)) begin
                @(negedge clk);
                wait_cycles++;
            end
            assert (card_count == t + 1) else begin
                $display("Test %s: the card model captured no command frame", names[t]);
                test_failed = 1'b1;
            end

            head      = {1'b0, 1'b1, rows[t].index, rows[t].arg};
            exp_frame = {head, crc7(128'(head), 40), 1'b1};
            assert (card_frame == exp_frame) else begin
                $display("[FAIL] %s frame: expected %h actual %h",
                    names[t], exp_frame, card_frame);
                test_failed = 1'b1;
            end
            assert (card_released == 1'b1) else begin
                $display("[FAIL] %s line after end bit: expected 1 actual %b",
                    names[t], card_released);
                test_failed = 1'b1;
            end
            assert (cmd_error == rows[t].expect_error) else begin
                $display("[FAIL] %s cmd_error: expected %b actual %b",
                    names[t], rows[t].expect_error, cmd_error);
                test_failed = 1'b1;
            end

            rsp_index = rows[t].override_en ? rows[t].override_index : rows[t].index;
            if (rows[t].kind == RSP_LONG) begin
                exp_long = {2'b00, rsp_index, random_bits[119:0]};
                assert (cmd_rsp == exp_long) else begin
                    $display("[FAIL] %s cmd_rsp: expected %h actual %h",
                        names[t], exp_long, cmd_rsp);
                    test_failed = 1'b1;
                end
            end else if (rows[t].kind == RSP_SHORT) begin
                exp_short = {2'b00, rsp_index, random_bits[31:0]};
                assert (cmd_rsp[39:0] == exp_short) else begin
                    $display("[FAIL] %s cmd_rsp: expected %h actual %h",
                        names[t], exp_short, cmd_rsp[39:0]);
                    test_failed = 1'b1;
                end
            end

            if (test_failed) begin
                fail_count++;
                $display("Test %s failed", names[t]);
            end else begin
                pass_count++;
                $display("Test %s passed", names[t]);
            end
            repeat (GAP_CYCLES) @(negedge clk);
        end

        $display("Tests passed: %0d, tests failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: sd_cmd_host.f
rtl/sd_pkg.sv
rtl/sd_clock_gen.sv
rtl/sd_crc_7.sv
rtl/sd_cmd.sv
rtl/sd_cmd_host.sv
test/tb_clock.sv
test/sd_card_model.sv
test/tb_sd_cmd_host.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_sd_cmd_host
FILELIST  = sd_cmd_host.f

OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(shell grep -v '^+' $(FILELIST))
LOG       = sim.log
FAIL_MSG  = Finished with errors
PASS_MSG  = Finished with no errors

.PHONY: all run clean

all: $(SIM_BIN)

$(OBJ_DIR)/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation did not complete"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
